// ==== flist.f ====
rtl/game_pkg.sv
rtl/score_pkg.sv
rtl/point_select.sv
rtl/score_accum.sv
rtl/bcd_convert.sv
rtl/score_pipe.sv
sim/score_pipe_assert.sv
sim/score_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the score pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module score_pipe_tb -f flist.f -o score_pipe_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/score_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== sim/score_pipe_tb.sv ====
`timescale 1ns/100ps

module score_pipe_tb;

	import game_pkg::*;
	import score_pkg::*;

	localparam int N_EVENTS       = 300;
	localparam int N_SAT          = 120;               // 120 * 9 is well past 999
	localparam int SAT_START      = 100;               // saturation run begins here
	localparam int TIMEOUT_CYCLES = N_EVENTS * 30;     // about 13 cycles per record needed
	localparam int SEED           = 24;

	logic        clk          = 1'b0;
	logic        rst_n        = 1'b0;
	logic        ev_valid     = 1'b0;
	point_ev_t   ev           = '0;
	logic        ev_credit;
	logic        score_valid;
	score_rec_t  score;
	logic        score_credit = 1'b0;

	point_ev_t   send_q[$];                            // events still to send
	string       send_name_q[$];
	score_rec_t  exp_q[$];                             // expected records, in order
	string       exp_name_q[$];
	int          due_q[$];                             // cycles for sink credit pulses
	int          src_cred     = EV_DEPTH;              // source view of point_select fifo
	int          cred_back    = 0;
	int          model_score  = 0;
	int          next_score;
	int          rx_cnt       = 0;
	int          cycle_cnt    = 0;
	int          last_due     = 0;
	int          due;
	point_ev_t   next_ev;
	score_rec_t  src_rec;
	score_rec_t  rx_rec;
	string       rx_name;

	score_pipe u_score_pipe (
		.clk          (clk),
		.rst_n        (rst_n),
		.ev_valid     (ev_valid),
		.ev           (ev),
		.ev_credit    (ev_credit),
		.score_valid  (score_valid),
		.score        (score),
		.score_credit (score_credit)
	);

	bind score_pipe score_pipe_assert u_score_pipe_assert (
		.clk          (clk),
		.rst_n        (rst_n),
		.score_valid  (score_valid),
		.score        (score),
		.score_credit (score_credit)
	);

	always #20 clk = ~clk;                             // 40 ns period

	//////////////////////////////////////////////////
	// reference model

	function automatic int game_weight(input logic [2:0] code);
		case (code)
			3'd0, 3'd1: return 1;                      // flick_master, touch_number
			3'd2, 3'd3: return 2;                      // follow_order, unfollow_order
			3'd4, 3'd5: return 3;                      // high_or_low, rainfall
			default:    return 0;                      // unused codes
		endcase
	endfunction

	function automatic score_rec_t predict_record(input int cur, input point_ev_t e,
			output int nxt);
		score_rec_t rec;
		if (e.op == ev_clear)
			nxt = 0;
		else begin
			nxt = cur + int'(e.point) * game_weight(e.game);
			if (nxt > int'(SCORE_MAX))
				nxt = int'(SCORE_MAX);                 // saturate, no wrap
		end
		rec.score = SCORE_W'(nxt);
		rec.hund  = bcd_digit_t'(nxt / 100);
		rec.tens  = bcd_digit_t'((nxt / 10) % 10);
		rec.unit  = bcd_digit_t'(nxt % 10);
		return rec;
	endfunction

	task automatic fail_run();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", test_name, expected, actual);
			fail_run();
		end
	endtask

	task automatic build_events();
		point_ev_t e;
		for (int i = 0; i < N_EVENTS; i++) begin
			if (i >= SAT_START && i < SAT_START + N_SAT)
				e = {ev_point, (i % 2 != 0) ? rainfall : high_or_low, 2'd3};  // delta 9
			else if (i == SAT_START + N_SAT)
				e = {ev_clear, flick_master, 2'd2};    // clear straight after the limit
			else
				e = {($urandom_range(19, 0) == 0), 3'($urandom_range(7, 0)),
					2'($urandom_range(3, 0))};         // about one clear in twenty
			send_q.push_back(e);
			if (e.op == ev_clear)
				send_name_q.push_back("clear");
			else if (i >= SAT_START && i < SAT_START + N_SAT)
				send_name_q.push_back("saturation");
			else
				send_name_q.push_back("weighting");
		end
	endtask

	//////////////////////////////////////////////////
	// source, sink, compare, timeout

	always @(posedge clk) begin
		if (rst_n) begin
			if (ev_credit) begin
				src_cred  = src_cred + 1;
				cred_back = cred_back + 1;
			end
			if (src_cred > EV_DEPTH) begin
				$display("error: ev_credit returned more than %0d credits", EV_DEPTH);
				fail_run();
			end else if (src_cred > 0 && send_q.size() != 0) begin
				next_ev  = send_q.pop_front();
				ev_valid <= 1'b1;
				ev       <= next_ev;
				src_cred = src_cred - 1;               // spent on this valid
				src_rec  = predict_record(model_score, next_ev, next_score);
				model_score = next_score;
				exp_q.push_back(src_rec);
				exp_name_q.push_back(send_name_q.pop_front());
			end else
				ev_valid <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			if (score_valid) begin
				due = cycle_cnt + int'($urandom_range(8, 0));
				if (due <= last_due)
					due = last_due + 1;                // one credit pulse per cycle
				last_due = due;
				due_q.push_back(due);
			end
			if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
				void'(due_q.pop_front());
				score_credit <= 1'b1;
			end else
				score_credit <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rst_n && score_valid) begin
			if (exp_q.size() == 0) begin
				$display("error: record arrived with no event left to match it");
				fail_run();
			end else begin
				rx_rec  = exp_q.pop_front();
				rx_name = exp_name_q.pop_front();
				rx_cnt  = rx_cnt + 1;
				check_value($sformatf("%s record %0d", rx_name, rx_cnt), 32'(rx_rec),
					32'(score));
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("error: run timed out after %0d cycles, %0d records seen",
				cycle_cnt, rx_cnt);
			fail_run();
		end
	end

	initial begin
		void'($urandom(SEED));
		build_events();
		repeat (3) @(posedge clk);                     // reset held 3 cycles
		rst_n <= 1'b1;
		while (rx_cnt < N_EVENTS)
			@(posedge clk);
		while (due_q.size() != 0)
			@(posedge clk);                            // let the sink return its credits
		@(negedge clk);
		if (exp_q.size() == 0 && src_cred == EV_DEPTH && cred_back == N_EVENTS) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("error: %0d records missing, %0d of %0d event credits returned",
				exp_q.size(), cred_back, N_EVENTS);
			fail_run();
		end
	end

endmodule

// ==== sim/score_pipe_assert.sv ====
`timescale 1ns/100ps

module score_pipe_assert (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   score_valid,
	input  score_pkg::score_rec_t  score,
	input  logic                   score_credit
);

	import score_pkg::*;

	logic [CRED_W-1:0] out_cnt;                        // records held by the sink

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_cnt <= '0;
		else begin
			case ({score_valid, score_credit})
				2'b10:   out_cnt <= out_cnt + 1'b1;
				2'b01:   out_cnt <= out_cnt - 1'b1;    // wraps high on a stray credit
				default: out_cnt <= out_cnt;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output record checks

	valid_in_reset: assert property (@(posedge clk) !rst_n |-> !score_valid)
		else $error("score_valid high during reset");

	digits_decimal: assert property (@(posedge clk) disable iff (!rst_n)
		score_valid |-> (score.hund <= 4'd9 && score.tens <= 4'd9 && score.unit <= 4'd9))
		else $error("bcd digit above 9");

	score_limit: assert property (@(posedge clk) disable iff (!rst_n)
		score_valid |-> score.score <= SCORE_MAX)
		else $error("score above limit");

	sink_credits: assert property (@(posedge clk) disable iff (!rst_n)
		out_cnt <= CRED_W'(OUT_CREDITS))
		else $error("more records outstanding than sink credits");

endmodule

// ==== rtl/score_pipe.sv ====
`timescale 1ns/100ps

module score_pipe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ev_valid,            // event from source
	input  game_pkg::point_ev_t    ev,
	output logic                   ev_credit,           // back to source
	output logic                   score_valid,         // record to sink
	output score_pkg::score_rec_t  score,
	input  logic                   score_credit         // back from sink
);

	import score_pkg::*;

	//////////////////////////////////////////////////
	// inter-stage links

	logic      delta_valid;                             // point_select -> score_accum
	delta_t    delta;
	logic      delta_credit;
	logic      sum_valid;                               // score_accum -> bcd_convert
	score_t    sum;
	logic      sum_credit;

	point_select u_point_select (
		.clk          (clk),
		.rst_n        (rst_n),
		.ev_valid     (ev_valid),
		.ev           (ev),
		.ev_credit    (ev_credit),
		.delta_valid  (delta_valid),
		.delta        (delta),
		.delta_credit (delta_credit)
	);

	score_accum u_score_accum (
		.clk          (clk),
		.rst_n        (rst_n),
		.delta_valid  (delta_valid),
		.delta        (delta),
		.delta_credit (delta_credit),
		.sum_valid    (sum_valid),
		.sum          (sum),
		.sum_credit   (sum_credit)
	);

	bcd_convert u_bcd_convert (
		.clk          (clk),
		.rst_n        (rst_n),
		.sum_valid    (sum_valid),
		.sum          (sum),
		.sum_credit   (sum_credit),
		.score_valid  (score_valid),
		.score        (score),
		.score_credit (score_credit)
	);

endmodule

// ==== rtl/bcd_convert.sv ====
`timescale 1ns/100ps

module bcd_convert (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   sum_valid,           // from score_accum
	input  score_pkg::score_t      sum,
	output logic                   sum_credit,          // one per loaded record
	output logic                   score_valid,         // to sink
	output score_pkg::score_rec_t  score,
	input  logic                   score_credit         // sink slot freed
);

	import score_pkg::*;

	typedef enum logic [1:0] {
		idle,                                           // wait for a record
		shift,                                          // double dabble steps
		hold                                            // result held until an output credit
	} conv_state_e;

	score_t                      fifo_mem [STAGE_DEPTH];
	logic [STAGE_PTR_W-1:0]      wr_ptr;
	logic [STAGE_PTR_W-1:0]      rd_ptr;
	logic [STAGE_PTR_W:0]        fill;
	conv_state_e                 state;
	logic [CNT_W-1:0]            shift_cnt;
	logic [DD_W-1:0]             dd_q;                  // {hund, tens, unit, binary}
	logic [DD_W-1:0]             dd_adj;                // digits corrected before shift
	logic [SCORE_W-1:0]          bin_q;                 // binary score kept for the record
	logic [CRED_W-1:0]           out_cred;              // sink credits
	logic                        pop;
	logic                        fire;
	score_t                      head;

	assign head    = fifo_mem[rd_ptr];
	assign pop     = (state == idle) && (fill != '0);   // load cycle
	assign fire    = (state == hold) && (out_cred != '0);

	//////////////////////////////////////////////////
	// record fifo

	always_ff @(posedge clk) begin
		if (sum_valid)
			fifo_mem[wr_ptr] <= sum;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (sum_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({sum_valid, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// add 3 to any digit of 5 or more
	always_comb begin
		dd_adj = dd_q;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (dd_q[SCORE_W + i * DIGIT_W +: DIGIT_W] >= DIGIT_W'(5))
				dd_adj[SCORE_W + i * DIGIT_W +: DIGIT_W] =
					dd_q[SCORE_W + i * DIGIT_W +: DIGIT_W] + DIGIT_W'(3);
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			bin_q <= head.score;                        // already 0 after a clear
			dd_q  <= {{(NUM_DIGITS * DIGIT_W){1'b0}}, head.score};  // digits start at 0
		end else if (state == shift)
			dd_q <= {dd_adj[DD_W-2:0], 1'b0};
	end

	//////////////////////////////////////////////////
	// conversion fsm and output credits

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= idle;
			shift_cnt   <= '0;
			score_valid <= 1'b0;
			score       <= '0;
			out_cred    <= CRED_W'(OUT_CREDITS);
		end else begin
			score_valid <= fire;                        // 12th cycle after load at the earliest
			case (state)
				idle: begin
					shift_cnt <= '0;
					if (pop)
						state <= shift;
				end
				shift: begin
					shift_cnt <= shift_cnt + 1'b1;
					if (shift_cnt == CNT_W'(SCORE_W - 1))
						state <= hold;                  // ten shifts done
				end
				hold: begin
					if (fire) begin
						score.score <= bin_q;
						score.hund  <= dd_q[SCORE_W + 2 * DIGIT_W +: DIGIT_W];
						score.tens  <= dd_q[SCORE_W + DIGIT_W +: DIGIT_W];
						score.unit  <= dd_q[SCORE_W +: DIGIT_W];
						state       <= idle;
					end
				end
				default: state <= idle;
			endcase
			case ({fire, score_credit})
				2'b10:   out_cred <= out_cred - 1'b1;
				2'b01:   out_cred <= out_cred + 1'b1;
				default: out_cred <= out_cred;
			endcase
		end
	end

	assign sum_credit = pop;                            // entry leaves at load

endmodule

// ==== rtl/score_accum.sv ====
`timescale 1ns/100ps

module score_accum (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 delta_valid,           // from point_select
	input  score_pkg::delta_t    delta,
	output logic                 delta_credit,          // one per popped delta
	output logic                 sum_valid,             // to bcd_convert
	output score_pkg::score_t    sum,
	input  logic                 sum_credit             // slot freed in bcd_convert
);

	import game_pkg::*;
	import score_pkg::*;

	delta_t                      fifo_mem [STAGE_DEPTH];
	logic [STAGE_PTR_W-1:0]      wr_ptr;
	logic [STAGE_PTR_W-1:0]      rd_ptr;
	logic [STAGE_PTR_W:0]        fill;
	logic [CRED_W-1:0]           cred;                  // credits toward bcd_convert
	logic                        pop;
	delta_t                      head;
	logic [SCORE_W-1:0]          score_q;               // running score
	logic [SCORE_W:0]            raw_sum;               // one bit of headroom
	logic [SCORE_W-1:0]          next_score;

	assign pop  = (fill != '0) && (cred != '0);
	assign head = fifo_mem[rd_ptr];

	//////////////////////////////////////////////////
	// delta fifo

	always_ff @(posedge clk) begin
		if (delta_valid)
			fifo_mem[wr_ptr] <= delta;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (delta_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({delta_valid, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// saturating add, clear wins
	always_comb begin
		raw_sum = {1'b0, score_q} + {{(SCORE_W + 1 - DELTA_W){1'b0}}, head.delta};
		if (head.op == ev_clear)
			next_score = '0;
		else if (raw_sum > {1'b0, SCORE_MAX})
			next_score = SCORE_MAX;                     // hold at 999, never wrap
		else
			next_score = raw_sum[SCORE_W-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score_q   <= '0;
			sum_valid <= 1'b0;
			cred      <= CRED_W'(STAGE_DEPTH);
		end else begin
			sum_valid <= pop;                           // out one cycle after heading fifo
			if (pop)
				score_q <= next_score;
			case ({pop, sum_credit})
				2'b10:   cred <= cred - 1'b1;           // spent at pop, valid follows
				2'b01:   cred <= cred + 1'b1;
				default: cred <= cred;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			sum.op    <= head.op;
			sum.score <= next_score;
		end
	end

	assign delta_credit = pop;

endmodule

// ==== rtl/point_select.sv ====
`timescale 1ns/100ps

module point_select (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ev_valid,              // event from source
	input  game_pkg::point_ev_t  ev,
	output logic                 ev_credit,             // one per popped event
	output logic                 delta_valid,           // to score_accum
	output score_pkg::delta_t    delta,
	input  logic                 delta_credit           // slot freed in score_accum
);

	import game_pkg::*;
	import score_pkg::*;

	point_ev_t                   fifo_mem [EV_DEPTH];   // event buffer
	logic [EV_PTR_W-1:0]         wr_ptr;
	logic [EV_PTR_W-1:0]         rd_ptr;
	logic [EV_PTR_W:0]           fill;                  // entries held
	logic [CRED_W-1:0]           cred;                  // credits toward score_accum
	logic                        empty;
	logic                        pop;
	point_ev_t                   head;
	logic [WEIGHT_W-1:0]         weight;

	assign empty = (fill == '0);
	assign pop   = !empty && (cred != '0);              // head leaves when credit held
	assign head  = fifo_mem[rd_ptr];

	//////////////////////////////////////////////////
	// event fifo

	always_ff @(posedge clk) begin
		if (ev_valid)
			fifo_mem[wr_ptr] <= ev;                     // source credits keep this in range
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (ev_valid)
				wr_ptr <= wr_ptr + 1'b1;                // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({ev_valid, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;                  // both or none
			endcase
		end
	end

	//////////////////////////////////////////////////
	// credit counter toward score_accum

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cred <= CRED_W'(STAGE_DEPTH);               // receiver depth
		else begin
			case ({pop, delta_credit})
				2'b10:   cred <= cred - 1'b1;           // spent on valid
				2'b01:   cred <= cred + 1'b1;           // slot returned
				default: cred <= cred;
			endcase
		end
	end

	// weighting of the head event
	assign weight = GAME_WEIGHT[head.game];             // 0 for codes 6 and 7

	always_comb begin
		delta.op    = head.op;
		delta.delta = '0;                               // clear carries no points
		if (head.op == ev_point)
			delta.delta = DELTA_W'(head.point) * DELTA_W'(weight);
	end

	assign delta_valid = pop;
	assign ev_credit   = pop;                           // same cycle the entry leaves

endmodule

// ==== rtl/score_pkg.sv ====
package score_pkg;

	//////////////////////////////////////////////////
	// score format

	localparam int SCORE_W    = 10;                     // binary score width
	localparam int DELTA_W    = 4;                      // max delta 3 * 3
	localparam int DIGIT_W    = 4;                      // one bcd digit
	localparam int NUM_DIGITS = 3;                      // hund, tens, unit
	localparam int DD_W       = SCORE_W + NUM_DIGITS * DIGIT_W;  // double dabble reg
	localparam int CNT_W      = 4;                      // shift counter, counts to SCORE_W

	localparam logic [SCORE_W-1:0] SCORE_MAX = 10'd999; // saturation point

	typedef logic [DIGIT_W-1:0] bcd_digit_t;

	typedef struct packed {
		game_pkg::ev_op_e      op;
		logic [DELTA_W-1:0]    delta;                   // weighted points
	} delta_t;

	typedef struct packed {
		game_pkg::ev_op_e      op;
		logic [SCORE_W-1:0]    score;                   // running score after this op
	} score_t;

	typedef struct packed {
		logic [SCORE_W-1:0]    score;                   // binary score
		bcd_digit_t            hund;
		bcd_digit_t            tens;
		bcd_digit_t            unit;
	} score_rec_t;

	//////////////////////////////////////////////////
	// link buffering and credits

	localparam int EV_DEPTH    = 4;                     // point_select event fifo
	localparam int STAGE_DEPTH = 2;                     // score_accum / bcd_convert fifo
	localparam int OUT_CREDITS = 2;                     // sink buffer slots
	localparam int EV_PTR_W    = 2;                     // log2 EV_DEPTH
	localparam int STAGE_PTR_W = 1;                     // log2 STAGE_DEPTH
	localparam int CRED_W      = 3;                     // holds up to EV_DEPTH

endpackage

// ==== rtl/game_pkg.sv ====
package game_pkg;

	//////////////////////////////////////////////////
	// event field widths

	localparam int GAME_W   = 3;                        // game id code width
	localparam int POINT_W  = 2;                        // raw point width
	localparam int WEIGHT_W = 2;                        // weight table entry width

	//////////////////////////////////////////////////
	// encodings

	typedef enum logic [GAME_W-1:0] {
		flick_master   = 3'd0,                          // weight 1
		touch_number   = 3'd1,                          // weight 1
		follow_order   = 3'd2,                          // weight 2
		unfollow_order = 3'd3,                          // weight 2
		high_or_low    = 3'd4,                          // weight 3
		rainfall       = 3'd5                           // weight 3, codes 6 and 7 unused
	} game_id_e;

	typedef enum logic {
		ev_point = 1'b0,                                // add weighted points
		ev_clear = 1'b1                                 // game back to initial state
	} ev_op_e;

	// multiplier per game, index is the game code
	localparam logic [2**GAME_W-1:0][WEIGHT_W-1:0] GAME_WEIGHT = {
		2'd0, 2'd0,                                     // codes 7, 6
		2'd3, 2'd3,                                     // rainfall, high_or_low
		2'd2, 2'd2,                                     // unfollow_order, follow_order
		2'd1, 2'd1                                      // touch_number, flick_master
	};

	typedef struct packed {
		ev_op_e                op;                      // point or clear
		game_id_e              game;                    // source mini-game
		logic [POINT_W-1:0]    point;                   // raw points, ignored on clear
	} point_ev_t;

endpackage
